//--- Bender.yml
package:
  name: wisc_lite

sources:
  # Shared package first, then the core
  - files:
      - common/wisc_pkg.sv
      - core/reg_file.sv
      - core/decode_stage.sv
      - core/execute_stage.sv
      - core/result_stage.sv
      - source/wisc_lite_top.sv

  # Testbench
  - target: test
    files:
      - verification/wisc_lite_checker.sv
      - verification/wisc_lite_tb.sv

//--- common/wisc_pkg.sv
`default_nettype none

package wisc_pkg;

	// --------------------
	// Core sizes
	// --------------------
	localparam int DATA_W     = 16;
	localparam int REG_SEL_W  = 4;
	localparam int OP_W       = 4;
	localparam int IMM_W      = 8;
	// Word addressed by address bits 8:1
	localparam int DMEM_WORDS = 256;

	// --------------------
	// Opcodes
	// --------------------
	localparam logic [OP_W-1:0] OP_ADD = 4'd0;
	localparam logic [OP_W-1:0] OP_SUB = 4'd1;
	localparam logic [OP_W-1:0] OP_XOR = 4'd2;
	localparam logic [OP_W-1:0] OP_AND = 4'd3;
	localparam logic [OP_W-1:0] OP_SLL = 4'd4;
	localparam logic [OP_W-1:0] OP_SRA = 4'd5;
	localparam logic [OP_W-1:0] OP_ROR = 4'd6;
	localparam logic [OP_W-1:0] OP_LW  = 4'd8;
	localparam logic [OP_W-1:0] OP_SW  = 4'd9;
	localparam logic [OP_W-1:0] OP_LHB = 4'd10;
	localparam logic [OP_W-1:0] OP_LLB = 4'd11;
	localparam logic [OP_W-1:0] OP_HLT = 4'd15;

	// Register layout, also used for shifts and memory ops
	typedef struct packed {
		logic [OP_W-1:0]      opcode;
		logic [REG_SEL_W-1:0] rd;
		logic [REG_SEL_W-1:0] rs;
		logic [REG_SEL_W-1:0] rt;
	} r_form_t;

	// Byte immediate layout for LHB and LLB
	typedef struct packed {
		logic [OP_W-1:0]      opcode;
		logic [REG_SEL_W-1:0] rd;
		logic [IMM_W-1:0]     imm;
	} i_form_t;

	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_u;

endpackage

`default_nettype wire

//--- core/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [wisc_pkg::DATA_W-1:0]    instr,
	input  logic                          ex_mem_read,
	input  logic [wisc_pkg::REG_SEL_W-1:0] ex_rd,
	input  logic [wisc_pkg::DATA_W-1:0]    rs_data,
	input  logic [wisc_pkg::DATA_W-1:0]    rt_data,
	output logic [wisc_pkg::DATA_W-1:0]    pc_out,
	output logic [wisc_pkg::REG_SEL_W-1:0] rs_sel,
	output logic [wisc_pkg::REG_SEL_W-1:0] rt_sel,
	output logic [wisc_pkg::DATA_W-1:0]    idex_a_data,
	output logic [wisc_pkg::DATA_W-1:0]    idex_b_data,
	output logic [wisc_pkg::REG_SEL_W-1:0] idex_rs,
	output logic [wisc_pkg::REG_SEL_W-1:0] idex_rt,
	output logic [wisc_pkg::REG_SEL_W-1:0] idex_rd,
	output logic [wisc_pkg::OP_W-1:0]      idex_op,
	output logic [wisc_pkg::IMM_W-1:0]     idex_imm,
	output logic                          idex_reg_write,
	output logic                          idex_mem_read,
	output logic                          idex_mem_write,
	output logic                          idex_halt,
	output logic                          stall
);
	import wisc_pkg::*;

	logic [DATA_W-1:0] pc;
	instr_u            if_instr;
	logic              if_valid;
	logic              halted;
	logic              dec_valid;
	logic [OP_W-1:0]   op;
	logic              is_alu, is_shift, is_lw, is_sw, is_lhb, is_llb, is_hlt;
	logic              use_a, use_b;
	logic              writes_rd;
	logic              dec_hlt;
	logic              fetch_en;
	logic              issue;

	// --------------------
	// Fetch
	// --------------------
	assign fetch_en = !stall && !halted && !dec_hlt;
	assign pc_out   = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= '0;
			if_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			if (fetch_en) begin
				pc       <= pc + DATA_W'(2);
				if_valid <= 1'b1;
			end
			// Nothing after HLT is issued
			if (dec_hlt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_en)
			if_instr <= instr;
	end

	// --------------------
	// Decode
	// --------------------
	assign dec_valid = if_valid && !halted;
	assign op        = if_instr.r_form.opcode;

	assign is_alu   = op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND};
	assign is_shift = op inside {OP_SLL, OP_SRA, OP_ROR};
	assign is_lw    = (op == OP_LW);
	assign is_sw    = (op == OP_SW);
	assign is_lhb   = (op == OP_LHB);
	assign is_llb   = (op == OP_LLB);
	assign is_hlt   = (op == OP_HLT);

	// Source A is rd for SW and the half-word loads, source B is rs for memory ops
	assign rs_sel = (is_sw || is_lhb || is_llb) ? if_instr.r_form.rd : if_instr.r_form.rs;
	assign rt_sel = (is_lw || is_sw) ? if_instr.r_form.rs : if_instr.r_form.rt;

	assign use_a     = is_alu || is_shift || is_lhb || is_llb || is_sw;
	assign use_b     = is_alu || is_lw || is_sw;
	assign writes_rd = is_alu || is_shift || is_lhb || is_llb || is_lw;

	// Load in execute feeding a source here
	assign stall = dec_valid && ex_mem_read && (ex_rd != '0) &&
		((use_a && rs_sel == ex_rd) || (use_b && rt_sel == ex_rd));

	assign dec_hlt = dec_valid && is_hlt;
	assign issue   = dec_valid && !stall;

	// --------------------
	// ID/EX register
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idex_reg_write <= 1'b0;
			idex_mem_read  <= 1'b0;
			idex_mem_write <= 1'b0;
			idex_halt      <= 1'b0;
		end else begin
			idex_reg_write <= issue && writes_rd;
			idex_mem_read  <= issue && is_lw;
			idex_mem_write <= issue && is_sw;
			idex_halt      <= issue && is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		idex_a_data <= rs_data;
		idex_b_data <= rt_data;
		idex_rs     <= rs_sel;
		idex_rt     <= rt_sel;
		idex_rd     <= if_instr.r_form.rd;
		idex_op     <= op;
		idex_imm    <= if_instr.i_form.imm;
	end

	// A stall leaves a bubble in execute, so it never lasts two cycles
	a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !stall);

endmodule

`default_nettype wire

//--- core/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [wisc_pkg::DATA_W-1:0]    idex_a_data,
	input  logic [wisc_pkg::DATA_W-1:0]    idex_b_data,
	input  logic [wisc_pkg::REG_SEL_W-1:0] idex_rs,
	input  logic [wisc_pkg::REG_SEL_W-1:0] idex_rt,
	input  logic [wisc_pkg::REG_SEL_W-1:0] idex_rd,
	input  logic [wisc_pkg::OP_W-1:0]      idex_op,
	input  logic [wisc_pkg::IMM_W-1:0]     idex_imm,
	input  logic                          idex_reg_write,
	input  logic                          idex_mem_read,
	input  logic                          idex_mem_write,
	input  logic                          idex_halt,
	input  logic                          wb_en,
	input  logic [wisc_pkg::REG_SEL_W-1:0] wb_reg,
	input  logic [wisc_pkg::DATA_W-1:0]    wb_data,
	input  logic                          wbq_en,
	input  logic [wisc_pkg::REG_SEL_W-1:0] wbq_reg,
	input  logic [wisc_pkg::DATA_W-1:0]    wbq_data,
	output logic [wisc_pkg::DATA_W-1:0]    exmem_alu_result,
	output logic [wisc_pkg::DATA_W-1:0]    exmem_store_data,
	output logic [wisc_pkg::DATA_W-1:0]    exmem_mem_addr,
	output logic [wisc_pkg::REG_SEL_W-1:0] exmem_rd,
	output logic                          exmem_reg_write,
	output logic                          exmem_mem_read,
	output logic                          exmem_mem_write,
	output logic                          exmem_halt,
	output logic                          ex_mem_read,
	output logic [wisc_pkg::REG_SEL_W-1:0] ex_rd
);
	import wisc_pkg::*;

	logic [DATA_W-1:0]        op_a, op_b;
	logic [3:0]               shamt;
	logic signed [DATA_W-1:0] sra_out;
	logic [2*DATA_W-1:0]      ror_wide;
	logic [DATA_W-1:0]        offset;
	logic [DATA_W-1:0]        mem_addr;
	logic [DATA_W-1:0]        alu_out;

	// Newest producer wins: result stage, then the late WB copy
	function automatic logic [DATA_W-1:0] fwd(
		input logic [REG_SEL_W-1:0] sel,
		input logic [DATA_W-1:0]    reg_val,
		input logic                 new_en,
		input logic [REG_SEL_W-1:0] new_reg,
		input logic [DATA_W-1:0]    new_val,
		input logic                 old_en,
		input logic [REG_SEL_W-1:0] old_reg,
		input logic [DATA_W-1:0]    old_val
	);
		if (new_en && new_reg == sel)
			return new_val;
		if (old_en && old_reg == sel)
			return old_val;
		return reg_val;
	endfunction

	// --------------------
	// Forwarding
	// --------------------
	assign op_a = fwd(idex_rs, idex_a_data, wb_en, wb_reg, wb_data,
		wbq_en, wbq_reg, wbq_data);
	assign op_b = fwd(idex_rt, idex_b_data, wb_en, wb_reg, wb_data,
		wbq_en, wbq_reg, wbq_data);

	// --------------------
	// ALU and shifter
	// --------------------
	assign shamt    = idex_imm[3:0];
	assign sra_out  = $signed(op_a) >>> shamt;
	assign ror_wide = {op_a, op_a} >> shamt;

	always_comb begin
		case (idex_op)
			OP_ADD:  alu_out = op_a + op_b;
			OP_SUB:  alu_out = op_a - op_b;
			OP_XOR:  alu_out = op_a ^ op_b;
			OP_AND:  alu_out = op_a & op_b;
			OP_SLL:  alu_out = op_a << shamt;
			OP_SRA:  alu_out = sra_out;
			OP_ROR:  alu_out = ror_wide[DATA_W-1:0];
			// Byte goes over the old register value
			OP_LHB:  alu_out = {idex_imm, op_a[DATA_W/2-1:0]};
			OP_LLB:  alu_out = {op_a[DATA_W-1:DATA_W/2], idex_imm};
			default: alu_out = '0;
		endcase
	end

	// Word-aligned base plus doubled signed offset
	assign offset   = {{(DATA_W-5){idex_imm[3]}}, idex_imm[3:0], 1'b0};
	assign mem_addr = {op_b[DATA_W-1:1], 1'b0} + offset;

	// Load-use check in decode
	assign ex_mem_read = idex_mem_read;
	assign ex_rd       = idex_rd;

	// --------------------
	// EX/MEM register
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exmem_reg_write <= 1'b0;
			exmem_mem_read  <= 1'b0;
			exmem_mem_write <= 1'b0;
			exmem_halt      <= 1'b0;
		end else begin
			exmem_reg_write <= idex_reg_write;
			exmem_mem_read  <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
			exmem_halt      <= idex_halt;
		end
	end

	always_ff @(posedge clk) begin
		exmem_alu_result <= alu_out;
		exmem_store_data <= op_a;
		exmem_mem_addr   <= mem_addr;
		exmem_rd         <= idex_rd;
	end

	// Decode never issues a load and a store at once
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(exmem_mem_read && exmem_mem_write));

endmodule

`default_nettype wire

//--- core/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [wisc_pkg::REG_SEL_W-1:0] rs_sel,
	input  logic [wisc_pkg::REG_SEL_W-1:0] rt_sel,
	input  logic                          wb_en,
	input  logic [wisc_pkg::REG_SEL_W-1:0] wb_reg,
	input  logic [wisc_pkg::DATA_W-1:0]    wb_data,
	output logic [wisc_pkg::DATA_W-1:0]    rs_data,
	output logic [wisc_pkg::DATA_W-1:0]    rt_data
);
	import wisc_pkg::*;

	logic [DATA_W-1:0] regs [2**REG_SEL_W];
	logic              wr_ok;

	// r0 is never written, so it reads zero
	assign wr_ok = wb_en && (wb_reg != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_SEL_W; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write-through for a read in the writeback cycle
	assign rs_data = (wr_ok && wb_reg == rs_sel) ? wb_data : regs[rs_sel];
	assign rt_data = (wr_ok && wb_reg == rt_sel) ? wb_data : regs[rt_sel];

	// Result stage already drops writes to r0
	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> (wb_reg != '0));

endmodule

`default_nettype wire

//--- core/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [wisc_pkg::DATA_W-1:0]    exmem_alu_result,
	input  logic [wisc_pkg::DATA_W-1:0]    exmem_store_data,
	input  logic [wisc_pkg::DATA_W-1:0]    exmem_mem_addr,
	input  logic [wisc_pkg::REG_SEL_W-1:0] exmem_rd,
	input  logic                          exmem_reg_write,
	input  logic                          exmem_mem_read,
	input  logic                          exmem_mem_write,
	input  logic                          exmem_halt,
	output logic                          wb_en,
	output logic [wisc_pkg::REG_SEL_W-1:0] wb_reg,
	output logic [wisc_pkg::DATA_W-1:0]    wb_data,
	output logic                          wbq_en,
	output logic [wisc_pkg::REG_SEL_W-1:0] wbq_reg,
	output logic [wisc_pkg::DATA_W-1:0]    wbq_data,
	output logic                          hlt
);
	import wisc_pkg::*;

	logic [DATA_W-1:0]               dmem [DMEM_WORDS];
	logic [$clog2(DMEM_WORDS)-1:0]   dmem_idx;
	logic [DATA_W-1:0]               load_data;
	logic                            hlt_q;

	// --------------------
	// Data memory
	// --------------------
	assign dmem_idx = exmem_mem_addr[$clog2(DMEM_WORDS):1];

	always_ff @(posedge clk) begin
		if (exmem_mem_write)
			dmem[dmem_idx] <= exmem_store_data;
	end

	// Combinational read, same cycle as the address
	assign load_data = dmem[dmem_idx];

	// --------------------
	// Writeback
	// --------------------
	assign wb_data = exmem_mem_read ? load_data : exmem_alu_result;
	assign wb_reg  = exmem_rd;
	assign wb_en   = exmem_reg_write && (exmem_rd != '0);

	// Late copy for operands two instructions behind
	always_ff @(posedge clk) begin
		if (!rst_n)
			wbq_en <= 1'b0;
		else
			wbq_en <= wb_en;
	end

	always_ff @(posedge clk) begin
		wbq_reg  <= wb_reg;
		wbq_data <= wb_data;
	end

	// Halt is sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			hlt_q <= 1'b0;
		else if (exmem_halt)
			hlt_q <= 1'b1;
	end

	assign hlt = hlt_q || exmem_halt;

endmodule

`default_nettype wire

//--- source/wisc_lite_top.sv
`timescale 1ns/1ps
`default_nettype none

module wisc_lite_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [wisc_pkg::DATA_W-1:0]    instr,
	output logic [wisc_pkg::DATA_W-1:0]    pc_out,
	output logic                          hlt,
	output logic                          wb_en,
	output logic [wisc_pkg::REG_SEL_W-1:0] wb_reg,
	output logic [wisc_pkg::DATA_W-1:0]    wb_data
);
	import wisc_pkg::*;

	// Decode and register file
	logic [REG_SEL_W-1:0] rs_sel, rt_sel;
	logic [DATA_W-1:0]    rs_data, rt_data;

	// --------------------
	// ID/EX fields
	// --------------------
	logic [DATA_W-1:0]    idex_a_data, idex_b_data;
	logic [REG_SEL_W-1:0] idex_rs, idex_rt, idex_rd;
	logic [OP_W-1:0]      idex_op;
	logic [IMM_W-1:0]     idex_imm;
	logic                 idex_reg_write, idex_mem_read, idex_mem_write, idex_halt;

	// --------------------
	// EX/MEM fields
	// --------------------
	logic [DATA_W-1:0]    exmem_alu_result, exmem_store_data, exmem_mem_addr;
	logic [REG_SEL_W-1:0] exmem_rd;
	logic                 exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_halt;

	// Hazard and forwarding paths
	logic                 ex_mem_read;
	logic [REG_SEL_W-1:0] ex_rd;
	logic                 wbq_en;
	logic [REG_SEL_W-1:0] wbq_reg;
	logic [DATA_W-1:0]    wbq_data;

	decode_stage i_decode_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr          (instr),
		.ex_mem_read    (ex_mem_read),
		.ex_rd          (ex_rd),
		.rs_data        (rs_data),
		.rt_data        (rt_data),
		.pc_out         (pc_out),
		.rs_sel         (rs_sel),
		.rt_sel         (rt_sel),
		.idex_a_data    (idex_a_data),
		.idex_b_data    (idex_b_data),
		.idex_rs        (idex_rs),
		.idex_rt        (idex_rt),
		.idex_rd        (idex_rd),
		.idex_op        (idex_op),
		.idex_imm       (idex_imm),
		.idex_reg_write (idex_reg_write),
		.idex_mem_read  (idex_mem_read),
		.idex_mem_write (idex_mem_write),
		.idex_halt      (idex_halt),
		.stall          ()
	);

	reg_file i_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_sel  (rs_sel),
		.rt_sel  (rt_sel),
		.wb_en   (wb_en),
		.wb_reg  (wb_reg),
		.wb_data (wb_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	execute_stage i_execute_stage (
		.clk              (clk),
		.rst_n            (rst_n),
		.idex_a_data      (idex_a_data),
		.idex_b_data      (idex_b_data),
		.idex_rs          (idex_rs),
		.idex_rt          (idex_rt),
		.idex_rd          (idex_rd),
		.idex_op          (idex_op),
		.idex_imm         (idex_imm),
		.idex_reg_write   (idex_reg_write),
		.idex_mem_read    (idex_mem_read),
		.idex_mem_write   (idex_mem_write),
		.idex_halt        (idex_halt),
		.wb_en            (wb_en),
		.wb_reg           (wb_reg),
		.wb_data          (wb_data),
		.wbq_en           (wbq_en),
		.wbq_reg          (wbq_reg),
		.wbq_data         (wbq_data),
		.exmem_alu_result (exmem_alu_result),
		.exmem_store_data (exmem_store_data),
		.exmem_mem_addr   (exmem_mem_addr),
		.exmem_rd         (exmem_rd),
		.exmem_reg_write  (exmem_reg_write),
		.exmem_mem_read   (exmem_mem_read),
		.exmem_mem_write  (exmem_mem_write),
		.exmem_halt       (exmem_halt),
		.ex_mem_read      (ex_mem_read),
		.ex_rd            (ex_rd)
	);

	result_stage i_result_stage (
		.clk              (clk),
		.rst_n            (rst_n),
		.exmem_alu_result (exmem_alu_result),
		.exmem_store_data (exmem_store_data),
		.exmem_mem_addr   (exmem_mem_addr),
		.exmem_rd         (exmem_rd),
		.exmem_reg_write  (exmem_reg_write),
		.exmem_mem_read   (exmem_mem_read),
		.exmem_mem_write  (exmem_mem_write),
		.exmem_halt       (exmem_halt),
		.wb_en            (wb_en),
		.wb_reg           (wb_reg),
		.wb_data          (wb_data),
		.wbq_en           (wbq_en),
		.wbq_reg          (wbq_reg),
		.wbq_data         (wbq_data),
		.hlt              (hlt)
	);

endmodule

`default_nettype wire

//--- verification/wisc_lite_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wisc_lite_checker #(
	parameter int N_ROWS = 48
) (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          wb_en,
	input  logic [wisc_pkg::REG_SEL_W-1:0]                wb_reg,
	input  logic [wisc_pkg::DATA_W-1:0]                   wb_data,
	input  logic                                          hlt,
	input  logic [2*wisc_pkg::DATA_W+wisc_pkg::REG_SEL_W:0] rows [N_ROWS],
	output logic                                          done,
	output int                                            pass_count,
	output int                                            fail_count
);
	import wisc_pkg::*;

	// Cycles watched after halt for stray writes
	localparam int DRAIN_CYCLES = 4;
	// Write flag sits just above the register and value fields
	localparam int WR_BIT = DATA_W + REG_SEL_W;

	int   next_row;
	int   drain;
	logic hlt_seen;

	initial begin
		done       = 1'b0;
		pass_count = 0;
		fail_count = 0;
		next_row   = 0;
		drain      = 0;
		hlt_seen   = 1'b0;
	end

	// Index of the next row that expects a write, N_ROWS if none
	function automatic int next_write(input int from);
		for (int i = from; i < N_ROWS; i++) begin
			if (rows[i][WR_BIT])
				return i;
		end
		return N_ROWS;
	endfunction

	// --------------------
	// One retired write
	// --------------------
	task automatic check_write();
		int                   idx;
		logic [REG_SEL_W-1:0] exp_reg;
		logic [DATA_W-1:0]    exp_val;

		idx = next_write(next_row);
		if (hlt_seen) begin
			$display("write to r%0d with %h after halt at %0t, nothing should retire then",
				wb_reg, wb_data, $time);
			fail_count++;
		end else if (idx >= N_ROWS) begin
			$display("unexpected write to r%0d with %h at %0t, no writes left in the table",
				wb_reg, wb_data, $time);
			fail_count++;
		end else begin
			exp_reg = rows[idx][WR_BIT-1:DATA_W];
			exp_val = rows[idx][DATA_W-1:0];
			if (wb_reg === exp_reg && wb_data === exp_val) begin
				$display("row %0d: r%0d = %h ok", idx, wb_reg, wb_data);
				pass_count++;
			end else begin
				$display("error %0t: row %0d wrote r%0d = %h, expected r%0d = %h",
					$time, idx, wb_reg, wb_data, exp_reg, exp_val);
				fail_count++;
			end
			next_row = idx + 1;
		end
	endtask

	// --------------------
	// Halt bookkeeping
	// --------------------
	task automatic check_retired();
		int missing;
		int first;

		missing = 0;
		first   = next_write(next_row);
		for (int i = first; i < N_ROWS; i++) begin
			if (rows[i][WR_BIT])
				missing++;
		end
		if (missing > 0) begin
			$display("halt came with %0d expected writes missing, the first at row %0d",
				missing, first);
			fail_count += missing;
		end else begin
			$display("halt at %0t: all expected writes retired", $time);
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n === 1'b1 && !done) begin
			if (wb_en === 1'b1)
				check_write();
			if (hlt_seen) begin
				drain++;
				if (drain == DRAIN_CYCLES)
					done = 1'b1;
			end else if (hlt === 1'b1) begin
				hlt_seen = 1'b1;
				check_retired();
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/wisc_lite_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wisc_lite_tb;
	import wisc_pkg::*;

	localparam int CLK_NS       = 4;
	localparam int RESET_CYCLES = 8;
	// Table capacity, unused rows hold HLT
	localparam int N_ROWS       = 48;
	// Row layout: instruction, write flag, register, value
	localparam int ROW_W        = 2*DATA_W + REG_SEL_W + 1;
	localparam logic [DATA_W-1:0] IDLE_WORD = {OP_HLT, 12'h000};

	logic                 clk;
	logic                 rst_n;
	logic [DATA_W-1:0]    instr;
	logic [DATA_W-1:0]    pc_out;
	logic                 hlt;
	logic                 wb_en;
	logic [REG_SEL_W-1:0] wb_reg;
	logic [DATA_W-1:0]    wb_data;

	logic [ROW_W-1:0]     rows [N_ROWS];
	int                   n_rows;
	logic                 chk_done;
	int                   pass_count;
	int                   fail_count;

	wisc_lite_top i_wisc_lite_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.instr   (instr),
		.pc_out  (pc_out),
		.hlt     (hlt),
		.wb_en   (wb_en),
		.wb_reg  (wb_reg),
		.wb_data (wb_data)
	);

	wisc_lite_checker #(
		.N_ROWS (N_ROWS)
	) i_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_en      (wb_en),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.hlt        (hlt),
		.rows       (rows),
		.done       (chk_done),
		.pass_count (pass_count),
		.fail_count (fail_count)
	);

	// --------------------
	// Table helpers
	// --------------------
	function automatic instr_u r_word(
		input logic [OP_W-1:0]      op,
		input logic [REG_SEL_W-1:0] rd,
		input logic [REG_SEL_W-1:0] rs,
		input logic [REG_SEL_W-1:0] rt
	);
		instr_u w;

		w.r_form.opcode = op;
		w.r_form.rd     = rd;
		w.r_form.rs     = rs;
		w.r_form.rt     = rt;
		return w;
	endfunction

	function automatic instr_u i_word(
		input logic [OP_W-1:0]      op,
		input logic [REG_SEL_W-1:0] rd,
		input logic [IMM_W-1:0]     imm
	);
		instr_u w;

		w.i_form.opcode = op;
		w.i_form.rd     = rd;
		w.i_form.imm    = imm;
		return w;
	endfunction

	task automatic expect_write(
		input instr_u               w,
		input logic [REG_SEL_W-1:0] dst,
		input logic [DATA_W-1:0]    val
	);
		rows[n_rows] = {w, 1'b1, dst, val};
		n_rows++;
	endtask

	task automatic expect_none(input instr_u w);
		rows[n_rows] = {w, 1'b0, {REG_SEL_W{1'b0}}, {DATA_W{1'b0}}};
		n_rows++;
	endtask

	// --------------------
	// Program table
	// --------------------
	task automatic fill_program();
		for (int i = 0; i < N_ROWS; i++)
			rows[i] = {IDLE_WORD, 1'b0, {REG_SEL_W{1'b0}}, {DATA_W{1'b0}}};
		n_rows = 0;
		// Constants, r1 = 1234, r2 = ffff, r3 = 800f
		expect_write(i_word(OP_LLB, 4'd1, 8'h34), 4'd1, 16'h0034);
		expect_write(i_word(OP_LHB, 4'd1, 8'h12), 4'd1, 16'h1234);
		expect_write(i_word(OP_LLB, 4'd2, 8'hff), 4'd2, 16'h00ff);
		expect_write(i_word(OP_LHB, 4'd2, 8'hff), 4'd2, 16'hffff);
		expect_write(i_word(OP_LLB, 4'd3, 8'h0f), 4'd3, 16'h000f);
		expect_write(i_word(OP_LHB, 4'd3, 8'h80), 4'd3, 16'h800f);
		// Register ALU ops, two of them wrap
		expect_write(r_word(OP_ADD, 4'd4, 4'd1, 4'd3), 4'd4, 16'h9243);
		expect_write(r_word(OP_ADD, 4'd5, 4'd2, 4'd1), 4'd5, 16'h1233);
		expect_write(r_word(OP_SUB, 4'd6, 4'd1, 4'd2), 4'd6, 16'h1235);
		expect_write(r_word(OP_SUB, 4'd7, 4'd3, 4'd1), 4'd7, 16'h6ddb);
		expect_write(r_word(OP_XOR, 4'd8, 4'd1, 4'd3), 4'd8, 16'h923b);
		expect_write(r_word(OP_AND, 4'd9, 4'd1, 4'd2), 4'd9, 16'h1234);
		expect_write(r_word(OP_AND, 4'd10, 4'd3, 4'd1), 4'd10, 16'h0004);
		// Shifts by 0, 1 and 15
		expect_write(r_word(OP_SLL, 4'd11, 4'd1, 4'd0), 4'd11, 16'h1234);
		expect_write(r_word(OP_SLL, 4'd11, 4'd1, 4'd1), 4'd11, 16'h2468);
		expect_write(r_word(OP_SLL, 4'd11, 4'd3, 4'd15), 4'd11, 16'h8000);
		expect_write(r_word(OP_SRA, 4'd12, 4'd3, 4'd0), 4'd12, 16'h800f);
		expect_write(r_word(OP_SRA, 4'd12, 4'd3, 4'd1), 4'd12, 16'hc007);
		expect_write(r_word(OP_SRA, 4'd12, 4'd3, 4'd15), 4'd12, 16'hffff);
		expect_write(r_word(OP_SRA, 4'd13, 4'd1, 4'd1), 4'd13, 16'h091a);
		expect_write(r_word(OP_ROR, 4'd14, 4'd1, 4'd0), 4'd14, 16'h1234);
		expect_write(r_word(OP_ROR, 4'd14, 4'd1, 4'd1), 4'd14, 16'h091a);
		expect_write(r_word(OP_ROR, 4'd14, 4'd3, 4'd15), 4'd14, 16'h001f);
		// Dependent chain at distances one and two
		expect_write(r_word(OP_ADD, 4'd1, 4'd2, 4'd3), 4'd1, 16'h800e);
		expect_write(r_word(OP_ADD, 4'd4, 4'd1, 4'd1), 4'd4, 16'h001c);
		expect_write(r_word(OP_XOR, 4'd5, 4'd1, 4'd4), 4'd5, 16'h8012);
		expect_write(r_word(OP_SUB, 4'd6, 4'd4, 4'd5), 4'd6, 16'h800a);
		expect_write(r_word(OP_AND, 4'd7, 4'd5, 4'd6), 4'd7, 16'h8002);
		// Odd base r8 = 0021, second base r14 = 001a
		expect_write(i_word(OP_LHB, 4'd8, 8'h00), 4'd8, 16'h003b);
		expect_write(i_word(OP_LLB, 4'd8, 8'h21), 4'd8, 16'h0021);
		expect_write(i_word(OP_LLB, 4'd14, 8'h1a), 4'd14, 16'h001a);
		// Stores to 0024 and to 001a with offset -3
		expect_none(r_word(OP_SW, 4'd1, 4'd8, 4'd2));
		expect_none(r_word(OP_SW, 4'd7, 4'd8, 4'd13));
		// Each load feeds the next instruction
		expect_write(r_word(OP_LW, 4'd9, 4'd8, 4'd2), 4'd9, 16'h800e);
		expect_write(r_word(OP_ADD, 4'd10, 4'd9, 4'd2), 4'd10, 16'h800d);
		expect_write(r_word(OP_LW, 4'd11, 4'd14, 4'd0), 4'd11, 16'h8002);
		expect_write(r_word(OP_XOR, 4'd12, 4'd3, 4'd11), 4'd12, 16'h000d);
		// r0 stays zero
		expect_none(r_word(OP_ADD, 4'd0, 4'd1, 4'd2));
		expect_write(r_word(OP_ADD, 4'd13, 4'd0, 4'd1), 4'd13, 16'h800e);
		expect_write(r_word(OP_SUB, 4'd15, 4'd2, 4'd0), 4'd15, 16'hffff);
		// Halt, the word after it must never retire
		expect_none(r_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_none(r_word(OP_ADD, 4'd1, 4'd2, 4'd2));
	endtask

	// --------------------
	// Clock, feed, watchdog
	// --------------------
	initial begin
		clk = 1'b0;
		forever #(CLK_NS/2) clk = ~clk;
	end

	// Instruction memory stand-in, word index is pc_out / 2
	initial begin
		int idx;

		forever begin
			@(negedge clk);
			idx = int'(pc_out >> 1);
			if (idx < N_ROWS)
				instr = rows[idx][ROW_W-1 -: DATA_W];
			else
				instr = IDLE_WORD;
		end
	end

	initial begin
		wait (rst_n === 1'b1);
		#((n_rows * 3 + 40) * CLK_NS);
		$display("timeout: the core did not halt within %0d cycles after reset",
			n_rows * 3 + 40);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		rst_n = 1'b0;
		instr = '0;
		fill_program();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		wait (chk_done === 1'b1);
		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- wisc_lite.f
common/wisc_pkg.sv
core/reg_file.sv
core/decode_stage.sv
core/execute_stage.sv
core/result_stage.sv
source/wisc_lite_top.sv
verification/wisc_lite_checker.sv
verification/wisc_lite_tb.sv
